/* source/rdma_axil_cfg.svh */
/*
 * Widths and constants of the AXI-Lite register master.
 * Data and address widths must stay at 32 bits, and the marker
 * must be a value that PIDB never legally reaches.
 */

`ifndef RDMA_AXIL_CFG_SVH
`define RDMA_AXIL_CFG_SVH

`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Command data that selects the CIDB write-back
`define RQ_CIDB_MARKER 32'hffff_ffff

// Upper bound on PIDB reads in one RQ step
`define RQ_POLL_LIMIT 1024

`define AXIL_RESP_OKAY 2'b00

`endif

/* source/rdma_axil_pkg.sv */
/*
 * Shared types of the register master.
 * Widths follow the cfg header, which is pulled in here.
 */

`include "rdma_axil_cfg.svh"

package rdma_axil_pkg;

  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [1:0]              axil_resp_t;

  // Poll counter, one extra value so the limit itself fits
  typedef logic [$clog2(`RQ_POLL_LIMIT+1)-1:0] poll_cnt_t;

  typedef enum logic [1:0] {
    CMD_WRITE     = 2'd0,
    CMD_STAT_READ = 2'd1,
    CMD_RQ_STEP   = 2'd2
  } cmd_kind_e;

  typedef enum logic [2:0] {
    SEQ_IDLE      = 3'd0,
    SEQ_WRITE     = 3'd1,
    SEQ_READ      = 3'd2,
    SEQ_POLL      = 3'd3,
    SEQ_POLL_NEXT = 3'd4,
    SEQ_FINISH    = 3'd5
  } seq_state_e;

endpackage

/* source/rdma_axil_cmd_seq.sv */
/*
 * Command sequencer. One command at a time over a four-phase req/ack.
 * A poll stops on a PIDB match, on an error response, or at the poll limit.
 * An unknown command kind finishes at once with rsp_err set.
 */
`timescale 1ns/10ps

`include "rdma_axil_cfg.svh"

module rdma_axil_cmd_seq
  import rdma_axil_pkg::*;
(
  input  logic       axil_clk,
  input  logic       axil_rstn,
  input  logic       cmd_req,
  input  cmd_kind_e  cmd_kind,
  input  axil_addr_t cmd_addr,
  input  axil_data_t cmd_data,
  output logic       cmd_ack,
  output axil_data_t rsp_data,
  output logic       rsp_err,
  output logic       rsp_timeout,
  output logic       wr_req,
  output axil_addr_t wr_addr,
  output axil_data_t wr_data,
  input  logic       wr_ack,
  input  axil_resp_t wr_resp,
  output logic       rd_req,
  output axil_addr_t rd_addr,
  input  logic       rd_ack,
  input  axil_data_t rd_data,
  input  axil_resp_t rd_resp,
  output logic       poll_clear,
  output logic       poll_count,
  input  logic       poll_expired
);

  seq_state_e state;
  axil_data_t golden;
  axil_data_t pidb_last;
  logic       cmd_accept;
  logic       is_marker;

  assign cmd_accept = (state == SEQ_IDLE) && cmd_req && !cmd_ack;
  assign is_marker  = (cmd_data == `RQ_CIDB_MARKER);

  // ==================================================
  // Command payload and response data
  // ==================================================
  always_ff @(posedge axil_clk) begin
    if (cmd_accept) begin
      golden  <= cmd_data;
      wr_addr <= cmd_addr;
      rd_addr <= cmd_addr;
      // CIDB write-back sends the last PIDB seen
      wr_data <= (cmd_kind == CMD_RQ_STEP) ? pidb_last : cmd_data;
    end
    if ((state == SEQ_WRITE) && wr_ack) begin
      rsp_data <= wr_data;
    end
    if (((state == SEQ_READ) || (state == SEQ_POLL)) && rd_ack) begin
      rsp_data <= rd_data;
    end
  end

  // ==================================================
  // Sequencer FSM
  // ==================================================
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      state       <= SEQ_IDLE;
      cmd_ack     <= 1'b0;
      rsp_err     <= 1'b0;
      rsp_timeout <= 1'b0;
      wr_req      <= 1'b0;
      rd_req      <= 1'b0;
      poll_clear  <= 1'b0;
      poll_count  <= 1'b0;
      pidb_last   <= '0;
    end else begin
      poll_clear <= 1'b0;
      poll_count <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (cmd_ack && !cmd_req) begin
            cmd_ack <= 1'b0;
          end else if (cmd_accept) begin
            rsp_err     <= 1'b0;
            rsp_timeout <= 1'b0;
            case (cmd_kind)
              CMD_WRITE: begin
                wr_req <= 1'b1;
                state  <= SEQ_WRITE;
              end
              CMD_STAT_READ: begin
                rd_req <= 1'b1;
                state  <= SEQ_READ;
              end
              CMD_RQ_STEP: begin
                if (is_marker) begin
                  wr_req <= 1'b1;
                  state  <= SEQ_WRITE;
                end else begin
                  poll_clear <= 1'b1;
                  rd_req     <= 1'b1;
                  state      <= SEQ_POLL;
                end
              end
              default: begin
                rsp_err <= 1'b1;
                state   <= SEQ_FINISH;
              end
            endcase
          end
        end
        SEQ_WRITE: begin
          if (wr_ack) begin
            wr_req  <= 1'b0;
            rsp_err <= rsp_err | (wr_resp != `AXIL_RESP_OKAY);
            state   <= SEQ_FINISH;
          end
        end
        SEQ_READ: begin
          if (rd_ack) begin
            rd_req  <= 1'b0;
            rsp_err <= rsp_err | (rd_resp != `AXIL_RESP_OKAY);
            state   <= SEQ_FINISH;
          end
        end
        SEQ_POLL: begin
          if (rd_ack) begin
            rd_req     <= 1'b0;
            poll_count <= 1'b1;
            if (rd_resp != `AXIL_RESP_OKAY) begin
              rsp_err <= 1'b1;
              state   <= SEQ_FINISH;
            end else begin
              pidb_last <= rd_data;
              state     <= (rd_data == golden) ? SEQ_FINISH : SEQ_POLL_NEXT;
            end
          end
        end
        SEQ_POLL_NEXT: begin
          // rd_ack low lines up with the timer having taken the count
          if (!rd_ack) begin
            if (poll_expired) begin
              rsp_timeout <= 1'b1;
              state       <= SEQ_FINISH;
            end else begin
              rd_req <= 1'b1;
              state  <= SEQ_POLL;
            end
          end
        end
        SEQ_FINISH: begin
          if (!wr_ack && !rd_ack) begin
            cmd_ack <= 1'b1;
            state   <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

/* source/rdma_axil_poll_timer.sv */
/*
 * PIDB poll attempt counter, saturating at the poll limit.
 * poll_expired follows poll_count by one cycle.
 */
`timescale 1ns/10ps

`include "rdma_axil_cfg.svh"

module rdma_axil_poll_timer
  import rdma_axil_pkg::*;
(
  input  logic axil_clk,
  input  logic axil_rstn,
  input  logic poll_clear,
  input  logic poll_count,
  output logic poll_expired
);

  localparam poll_cnt_t POLL_LIMIT = poll_cnt_t'(`RQ_POLL_LIMIT);

  poll_cnt_t poll_cnt;

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      poll_cnt <= '0;
    end else if (poll_clear) begin
      poll_cnt <= '0;
    end else if (poll_count && !poll_expired) begin
      poll_cnt <= poll_cnt + 1'b1;
    end
  end

  assign poll_expired = (poll_cnt == POLL_LIMIT);

endmodule

/* source/rdma_axil_wr_chan.sv */
/*
 * Single AXI-Lite write, AW then W then B, never overlapped.
 * A new request starts only after wr_ack has dropped.
 */
`timescale 1ns/10ps

module rdma_axil_wr_chan
  import rdma_axil_pkg::*;
(
  input  logic       axil_clk,
  input  logic       axil_rstn,
  input  logic       wr_req,
  input  axil_addr_t wr_addr,
  input  axil_data_t wr_data,
  output logic       wr_ack,
  output axil_resp_t wr_resp,
  output logic       m_axil_awvalid,
  output axil_addr_t m_axil_awaddr,
  input  logic       m_axil_awready,
  output logic       m_axil_wvalid,
  output axil_data_t m_axil_wdata,
  input  logic       m_axil_wready,
  input  logic       m_axil_bvalid,
  input  axil_resp_t m_axil_bresp,
  output logic       m_axil_bready
);

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_ADDR = 2'd1,
    WR_DATA = 2'd2,
    WR_RESP = 2'd3
  } wr_state_e;

  wr_state_e state;

  // Address and data held in place through back-pressure
  always_ff @(posedge axil_clk) begin
    if ((state == WR_IDLE) && wr_req && !wr_ack) begin
      m_axil_awaddr <= wr_addr;
      m_axil_wdata  <= wr_data;
    end
    if ((state == WR_RESP) && m_axil_bvalid) begin
      wr_resp <= m_axil_bresp;
    end
  end

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      state          <= WR_IDLE;
      wr_ack         <= 1'b0;
      m_axil_awvalid <= 1'b0;
      m_axil_wvalid  <= 1'b0;
      m_axil_bready  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (wr_ack && !wr_req) begin
            wr_ack <= 1'b0;
          end else if (wr_req && !wr_ack) begin
            m_axil_awvalid <= 1'b1;
            state          <= WR_ADDR;
          end
        end
        WR_ADDR: begin
          if (m_axil_awready) begin
            m_axil_awvalid <= 1'b0;
            m_axil_wvalid  <= 1'b1;
            state          <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (m_axil_wready) begin
            m_axil_wvalid <= 1'b0;
            m_axil_bready <= 1'b1;
            state         <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (m_axil_bvalid) begin
            m_axil_bready <= 1'b0;
            wr_ack        <= 1'b1;
            state         <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule

/* source/rdma_axil_rd_chan.sv */
/*
 * Single AXI-Lite read, AR then R.
 * rd_data and rd_resp hold their value while rd_ack is high.
 */
`timescale 1ns/10ps

module rdma_axil_rd_chan
  import rdma_axil_pkg::*;
(
  input  logic       axil_clk,
  input  logic       axil_rstn,
  input  logic       rd_req,
  input  axil_addr_t rd_addr,
  output logic       rd_ack,
  output axil_data_t rd_data,
  output axil_resp_t rd_resp,
  output logic       m_axil_arvalid,
  output axil_addr_t m_axil_araddr,
  input  logic       m_axil_arready,
  input  logic       m_axil_rvalid,
  input  axil_data_t m_axil_rdata,
  input  axil_resp_t m_axil_rresp,
  output logic       m_axil_rready
);

  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    RD_ADDR = 2'd1,
    RD_DATA = 2'd2
  } rd_state_e;

  rd_state_e state;

  always_ff @(posedge axil_clk) begin
    if ((state == RD_IDLE) && rd_req && !rd_ack) begin
      m_axil_araddr <= rd_addr;
    end
    // Capture on the R handshake
    if ((state == RD_DATA) && m_axil_rvalid) begin
      rd_data <= m_axil_rdata;
      rd_resp <= m_axil_rresp;
    end
  end

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      state          <= RD_IDLE;
      rd_ack         <= 1'b0;
      m_axil_arvalid <= 1'b0;
      m_axil_rready  <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (rd_ack && !rd_req) begin
            rd_ack <= 1'b0;
          end else if (rd_req && !rd_ack) begin
            m_axil_arvalid <= 1'b1;
            state          <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (m_axil_arready) begin
            m_axil_arvalid <= 1'b0;
            m_axil_rready  <= 1'b1;
            state          <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (m_axil_rvalid) begin
            m_axil_rready <= 1'b0;
            rd_ack        <= 1'b1;
            state         <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

endmodule

/* source/rdma_axil_master.sv */
/*
 * AXI-Lite register master for the RDMA core.
 * Host side is a four-phase cmd_req/cmd_ack, one command in flight.
 * Waits on the AXI slave are unbounded; only PIDB polling is limited.
 */
`timescale 1ns/10ps

module rdma_axil_master
  import rdma_axil_pkg::*;
(
  input  logic       axil_clk,
  input  logic       axil_rstn,
  input  logic       cmd_req,
  input  cmd_kind_e  cmd_kind,
  input  axil_addr_t cmd_addr,
  input  axil_data_t cmd_data,
  output logic       cmd_ack,
  output axil_data_t rsp_data,
  output logic       rsp_err,
  output logic       rsp_timeout,
  output logic       m_axil_awvalid,
  output axil_addr_t m_axil_awaddr,
  input  logic       m_axil_awready,
  output logic       m_axil_wvalid,
  output axil_data_t m_axil_wdata,
  input  logic       m_axil_wready,
  input  logic       m_axil_bvalid,
  input  axil_resp_t m_axil_bresp,
  output logic       m_axil_bready,
  output logic       m_axil_arvalid,
  output axil_addr_t m_axil_araddr,
  input  logic       m_axil_arready,
  input  logic       m_axil_rvalid,
  input  axil_data_t m_axil_rdata,
  input  axil_resp_t m_axil_rresp,
  output logic       m_axil_rready
);

  logic       wr_req;
  axil_addr_t wr_addr;
  axil_data_t wr_data;
  logic       wr_ack;
  axil_resp_t wr_resp;
  logic       rd_req;
  axil_addr_t rd_addr;
  logic       rd_ack;
  axil_data_t rd_data;
  axil_resp_t rd_resp;
  logic       poll_clear;
  logic       poll_count;
  logic       poll_expired;

  rdma_axil_cmd_seq cmd_seq_i (
    .axil_clk     (axil_clk),
    .axil_rstn    (axil_rstn),
    .cmd_req      (cmd_req),
    .cmd_kind     (cmd_kind),
    .cmd_addr     (cmd_addr),
    .cmd_data     (cmd_data),
    .cmd_ack      (cmd_ack),
    .rsp_data     (rsp_data),
    .rsp_err      (rsp_err),
    .rsp_timeout  (rsp_timeout),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_ack       (wr_ack),
    .wr_resp      (wr_resp),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .rd_ack       (rd_ack),
    .rd_data      (rd_data),
    .rd_resp      (rd_resp),
    .poll_clear   (poll_clear),
    .poll_count   (poll_count),
    .poll_expired (poll_expired)
  );

  rdma_axil_poll_timer poll_timer_i (
    .axil_clk     (axil_clk),
    .axil_rstn    (axil_rstn),
    .poll_clear   (poll_clear),
    .poll_count   (poll_count),
    .poll_expired (poll_expired)
  );

  rdma_axil_wr_chan wr_chan_i (
    .axil_clk       (axil_clk),
    .axil_rstn      (axil_rstn),
    .wr_req         (wr_req),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .wr_ack         (wr_ack),
    .wr_resp        (wr_resp),
    .m_axil_awvalid (m_axil_awvalid),
    .m_axil_awaddr  (m_axil_awaddr),
    .m_axil_awready (m_axil_awready),
    .m_axil_wvalid  (m_axil_wvalid),
    .m_axil_wdata   (m_axil_wdata),
    .m_axil_wready  (m_axil_wready),
    .m_axil_bvalid  (m_axil_bvalid),
    .m_axil_bresp   (m_axil_bresp),
    .m_axil_bready  (m_axil_bready)
  );

  rdma_axil_rd_chan rd_chan_i (
    .axil_clk       (axil_clk),
    .axil_rstn      (axil_rstn),
    .rd_req         (rd_req),
    .rd_addr        (rd_addr),
    .rd_ack         (rd_ack),
    .rd_data        (rd_data),
    .rd_resp        (rd_resp),
    .m_axil_arvalid (m_axil_arvalid),
    .m_axil_araddr  (m_axil_araddr),
    .m_axil_arready (m_axil_arready),
    .m_axil_rvalid  (m_axil_rvalid),
    .m_axil_rdata   (m_axil_rdata),
    .m_axil_rresp   (m_axil_rresp),
    .m_axil_rready  (m_axil_rready)
  );

endmodule

/* sim/axil_slave_model.sv */
/*
 * AXI-Lite slave for simulation. 16 words at 0x000..0x03c, PIDB at 0x040.
 * PIDB returns its value and then counts up on every read.
 * Addresses at 0x100 and above answer SLVERR; other addresses read 0.
 * Ready delays come from ready_delay, taken after each handshake.
 */
`timescale 1ns/10ps

`include "rdma_axil_cfg.svh"

module axil_slave_model
  import rdma_axil_pkg::*;
(
  input  logic       axil_clk,
  input  logic       axil_rstn,
  input  logic [1:0] ready_delay,
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  output logic       wready,
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready
);

  localparam axil_resp_t RESP_SLVERR = 2'b10;

  axil_data_t mem [16];
  axil_data_t pidb;
  axil_addr_t aw_addr_q;
  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic [1:0] ar_wait;

  always @(posedge axil_clk) begin
    if (!axil_rstn) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= `AXIL_RESP_OKAY;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rdata     <= '0;
      rresp     <= `AXIL_RESP_OKAY;
      pidb      <= '0;
      aw_addr_q <= '0;
      aw_wait   <= 2'd0;
      w_wait    <= 2'd0;
      ar_wait   <= 2'd0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // ==================================================
      // Write side
      // ==================================================
      if (awvalid && awready) begin
        awready   <= 1'b0;
        aw_addr_q <= awaddr;
        aw_wait   <= ready_delay;
      end else if (awvalid) begin
        if (aw_wait == 2'd0) awready <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end

      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end

      if (wvalid && wready) begin
        wready <= 1'b0;
        w_wait <= ready_delay;
        bvalid <= 1'b1;
        if (aw_addr_q >= 32'h100) begin
          bresp <= RESP_SLVERR;
        end else begin
          bresp <= `AXIL_RESP_OKAY;
          if (aw_addr_q < 32'h40) mem[aw_addr_q[5:2]] <= wdata;
        end
      end else if (wvalid) begin
        if (w_wait == 2'd0) wready <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end

      // ==================================================
      // Read side
      // ==================================================
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end

      if (arvalid && arready) begin
        arready <= 1'b0;
        ar_wait <= ready_delay;
        rvalid  <= 1'b1;
        rresp   <= `AXIL_RESP_OKAY;
        rdata   <= '0;
        if (araddr >= 32'h100) begin
          rresp <= RESP_SLVERR;
        end else if (araddr == 32'h40) begin
          rdata <= pidb;
          pidb  <= pidb + 32'd1;
        end else if (araddr < 32'h40) begin
          rdata <= mem[araddr[5:2]];
        end
      end else if (arvalid) begin
        if (ar_wait == 2'd0) arready <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
    end
  end

endmodule

/* sim/tb_rdma_axil_master.sv */
/*
 * Testbench of the AXI-Lite register master.
 * Expected responses come from a mirror of the slave model rules.
 * Each wait on cmd_ack gives up after ACK_TIMEOUT cycles.
 */
`timescale 1ns/10ps

`include "rdma_axil_cfg.svh"

module tb_rdma_axil_master
  import rdma_axil_pkg::*;
();

  localparam int DW          = `AXIL_DATA_W;
  localparam int RSP_W       = `AXIL_DATA_W + 2;
  localparam int ACK_TIMEOUT = 40000;

  logic       axil_clk = 1'b0;
  logic       axil_rstn;
  logic       cmd_req;
  cmd_kind_e  cmd_kind;
  axil_addr_t cmd_addr;
  axil_data_t cmd_data;
  logic       cmd_ack;
  axil_data_t rsp_data;
  logic       rsp_err;
  logic       rsp_timeout;

  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  axil_resp_t bresp, rresp;

  logic [31:0] delay_state = 32'hc44;
  logic [31:0] stim_state = 32'hc44;
  int          checks = 0;
  int          errors = 0;
  logic        ack_q = 1'b0;
  logic [RSP_W-1:0] exp_rsp;
  logic [RSP_W-1:0] exp_q [$];

  // Slave mirror
  axil_data_t mem_mirror [16];
  axil_data_t pidb_mirror;
  axil_data_t pidb_last_mirror;

  always #2 axil_clk = ~axil_clk;

  rdma_axil_master rdma_axil_master_i (
    .axil_clk       (axil_clk),
    .axil_rstn      (axil_rstn),
    .cmd_req        (cmd_req),
    .cmd_kind       (cmd_kind),
    .cmd_addr       (cmd_addr),
    .cmd_data       (cmd_data),
    .cmd_ack        (cmd_ack),
    .rsp_data       (rsp_data),
    .rsp_err        (rsp_err),
    .rsp_timeout    (rsp_timeout),
    .m_axil_awvalid (awvalid),
    .m_axil_awaddr  (awaddr),
    .m_axil_awready (awready),
    .m_axil_wvalid  (wvalid),
    .m_axil_wdata   (wdata),
    .m_axil_wready  (wready),
    .m_axil_bvalid  (bvalid),
    .m_axil_bresp   (bresp),
    .m_axil_bready  (bready),
    .m_axil_arvalid (arvalid),
    .m_axil_araddr  (araddr),
    .m_axil_arready (arready),
    .m_axil_rvalid  (rvalid),
    .m_axil_rdata   (rdata),
    .m_axil_rresp   (rresp),
    .m_axil_rready  (rready)
  );

  axil_slave_model slave_i (
    .axil_clk    (axil_clk),
    .axil_rstn   (axil_rstn),
    .ready_delay (delay_state[1:0]),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .awready     (awready),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .bready      (bready),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rready      (rready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always @(posedge axil_clk) delay_state <= xorshift32(delay_state);

  // ==================================================
  // Reference model
  // ==================================================
  // Returns {err, data} and counts PIDB up on each read
  function automatic logic [DW:0] mirror_read(input axil_addr_t addr);
    axil_data_t value;
    value = '0;
    if (addr >= 32'h100) return {1'b1, value};
    if (addr == 32'h40) begin
      value       = pidb_mirror;
      pidb_mirror = pidb_mirror + 32'd1;
    end else if (addr < 32'h40) begin
      value = mem_mirror[addr[5:2]];
    end
    return {1'b0, value};
  endfunction

  function automatic logic mirror_write(input axil_addr_t addr, input axil_data_t data);
    if (addr >= 32'h100) return 1'b1;
    if (addr < 32'h40) mem_mirror[addr[5:2]] = data;
    return 1'b0;
  endfunction

  // Returns {rsp_err, rsp_timeout, rsp_data}
  function automatic logic [RSP_W-1:0] expect_rsp(input cmd_kind_e kind,
                                                  input axil_addr_t addr,
                                                  input axil_data_t data);
    logic [DW:0] rd;
    axil_data_t  value;
    logic        err;
    logic        tmo;
    int          n;
    value = data;
    err   = 1'b0;
    tmo   = 1'b0;
    case (kind)
      CMD_WRITE: err = mirror_write(addr, data);
      CMD_STAT_READ: begin
        rd    = mirror_read(addr);
        err   = rd[DW];
        value = rd[DW-1:0];
      end
      default: begin
        if (data == `RQ_CIDB_MARKER) begin
          value = pidb_last_mirror;
          err   = mirror_write(addr, value);
        end else begin
          n   = 0;
          tmo = 1'b1;
          while (n < `RQ_POLL_LIMIT) begin
            rd    = mirror_read(addr);
            n     = n + 1;
            value = rd[DW-1:0];
            if (rd[DW]) begin
              err = 1'b1;
              tmo = 1'b0;
              break;
            end
            pidb_last_mirror = value;
            if (value == data) begin
              tmo = 1'b0;
              break;
            end
          end
        end
      end
    endcase
    return {err, tmo, value};
  endfunction

  // ==================================================
  // Checking
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  always @(posedge axil_clk) begin
    ack_q <= cmd_ack;
    if (axil_rstn === 1'b1 && cmd_ack === 1'b1 && ack_q === 1'b0) begin
      if (cmd_req !== 1'b1) begin
        errors++;
        $display("cmd_ack rose while cmd_req was low");
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("cmd_ack rose with no command outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_value("rsp_data", rsp_data, exp_rsp[DW-1:0]);
        check_value("rsp_timeout", {31'd0, rsp_timeout}, {31'd0, exp_rsp[DW]});
        check_value("rsp_err", {31'd0, rsp_err}, {31'd0, exp_rsp[DW+1]});
      end
    end
    if (axil_rstn === 1'b1 && cmd_ack === 1'b0 && ack_q === 1'b1 && cmd_req === 1'b1) begin
      errors++;
      $display("cmd_ack dropped while cmd_req was still high");
    end
  end

  task automatic end_run();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d commands finished without a checked response", exp_q.size());
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  task automatic wait_ack(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (cmd_ack !== level && cycles < ACK_TIMEOUT) begin
      @(posedge axil_clk);
      cycles++;
    end
    if (cmd_ack !== level) begin
      errors++;
      $display("Timed out %s", what);
      end_run();
    end
  endtask

  task automatic issue_cmd(input cmd_kind_e kind, input axil_addr_t addr,
                           input axil_data_t data);
    exp_q.push_back(expect_rsp(kind, addr, data));
    @(posedge axil_clk);
    cmd_kind <= kind;
    cmd_addr <= addr;
    cmd_data <= data;
    cmd_req  <= 1'b1;
    wait_ack(1'b1, "waiting for cmd_ack to rise");
    cmd_req <= 1'b0;
    wait_ack(1'b0, "waiting for cmd_ack to fall");
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    axil_addr_t addr;
    axil_data_t data;
    axil_rstn <= 1'b0;
    cmd_req   <= 1'b0;
    cmd_kind  <= CMD_WRITE;
    cmd_addr  <= '0;
    cmd_data  <= '0;
    for (int i = 0; i < 16; i++) mem_mirror[i] = '0;
    pidb_mirror      = '0;
    pidb_last_mirror = '0;
    repeat (8) @(posedge axil_clk);
    axil_rstn <= 1'b1;
    @(posedge axil_clk);

    // Write then read back random memory words
    for (int k = 0; k < 12; k++) begin
      stim_state = xorshift32(stim_state);
      addr       = {26'd0, stim_state[3:0], 2'b00};
      stim_state = xorshift32(stim_state);
      data       = stim_state;
      issue_cmd(CMD_WRITE, addr, data);
      issue_cmd(CMD_STAT_READ, addr, '0);
    end

    // Error window
    issue_cmd(CMD_STAT_READ, 32'h100, '0);
    issue_cmd(CMD_WRITE, 32'h104, 32'hdead_beef);
    issue_cmd(CMD_STAT_READ, 32'h104, '0);
    stim_state = xorshift32(stim_state);
    issue_cmd(CMD_WRITE, {20'd0, 2'b01, stim_state[7:0], 2'b00}, stim_state);

    // PIDB poll that matches after k extra reads
    for (int k = 0; k <= 20; k++) begin
      issue_cmd(CMD_RQ_STEP, 32'h40, pidb_mirror + k);
      issue_cmd(CMD_STAT_READ, 32'h40, '0);
    end

    // CIDB write-back of the last PIDB value
    issue_cmd(CMD_RQ_STEP, 32'h08, `RQ_CIDB_MARKER);
    issue_cmd(CMD_STAT_READ, 32'h08, '0);

    // Golden value already passed so the poll runs to the limit
    issue_cmd(CMD_RQ_STEP, 32'h40, pidb_mirror - 32'd1);
    issue_cmd(CMD_STAT_READ, 32'h40, '0);
    issue_cmd(CMD_RQ_STEP, 32'h3c, `RQ_CIDB_MARKER);
    issue_cmd(CMD_STAT_READ, 32'h3c, '0);

    repeat (4) @(posedge axil_clk);
    end_run();
  end

endmodule

/* project.f */
+incdir+source
source/rdma_axil_pkg.sv
source/rdma_axil_cmd_seq.sv
source/rdma_axil_poll_timer.sv
source/rdma_axil_wr_chan.sv
source/rdma_axil_rd_chan.sv
source/rdma_axil_master.sv
sim/axil_slave_model.sv
sim/tb_rdma_axil_master.sv

/* Bender.yml */
package:
  name: rdma_axil_master

sources:
  - include_dirs:
      - source
    files:
      - source/rdma_axil_pkg.sv
      - source/rdma_axil_cmd_seq.sv
      - source/rdma_axil_poll_timer.sv
      - source/rdma_axil_wr_chan.sv
      - source/rdma_axil_rd_chan.sv
      - source/rdma_axil_master.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/axil_slave_model.sv
      - sim/tb_rdma_axil_master.sv
